//--- filelist.f
+incdir+sim
common/io_pkg.sv
src/io_request_decoder.sv
gpio/gpio.sv
timer/machine_timer.sv
src/io_read_mux.sv
src/io_subsystem.sv
sim/tb_io_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the I/O subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing -f filelist.f --top-module tb_io_subsystem \
  --Mdir obj_dir -o tb_io_subsystem \
  && ./obj_dir/tb_io_subsystem > "$log" 2>&1 \
  || { echo "Build or simulation run failed"; cat "$log" 2>/dev/null; exit 1; }
cat "$log"
grep -qx "Result: PASSED" "$log" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim/tb_io_model.svh
//**************************************************************************
// Testbench model of the GPIO registers, expected read values and LFSR
//**************************************************************************

`ifndef TB_IO_MODEL_SVH
`define TB_IO_MODEL_SVH

// Register state as software sees it after each completed write
logic [gpio_width-1:0] model_oe   = '0;
logic [gpio_width-1:0] model_out  = '0;
logic [31:0]           lfsr_state = 32'ha2b7;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// Collects count random bits, one LFSR step per bit
function automatic logic [31:0] random_bits(input int count);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < count; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    value = {value[30:0], lfsr_state[0]};
  end
  return value;
endfunction

// Pin seen on IN: driven value where the pin is an output
function automatic logic [gpio_width-1:0] expected_pins(input logic [gpio_width-1:0] oe,
                                                        input logic [gpio_width-1:0] out,
                                                        input logic [gpio_width-1:0] pins);
  logic [gpio_width-1:0] value;
  for (int i = 0; i < gpio_width; i++) begin
    value[i] = oe[i] ? out[i] : pins[i];
  end
  return value;
endfunction

// Bus word expected from a GPIO register read
function automatic logic [31:0] expected_gpio_read(input logic [offset_width-1:0] offset,
                                                   input logic [gpio_width-1:0] pins);
  logic [31:0] word;
  word = '0;
  if (offset == reg_gpio_in) begin
    word[gpio_width-1:0] = expected_pins(model_oe, model_out, pins);
  end else if (offset == reg_gpio_oe) begin
    word[gpio_width-1:0] = model_oe;
  end else if (offset == reg_gpio_out) begin
    word[gpio_width-1:0] = model_out;
  end
  return word;
endfunction

// Only full aligned words into the GPIO region change the model
function automatic void apply_write(input logic [io_addr_width-1:0] address,
                                    input logic [31:0] data,
                                    input logic [3:0] strobe);
  logic [offset_width-1:0] offset;
  logic [gpio_width-1:0]   bits;
  offset = address[offset_width-1:0];
  bits   = data[gpio_width-1:0];
  if (address[io_addr_width-1:offset_width] == region_gpio && strobe == 4'hF
      && offset[1:0] == 2'b00) begin
    if (offset == reg_gpio_oe) model_oe = bits;
    if (offset == reg_gpio_out) model_out = bits;
    if (offset == reg_gpio_set) model_out = model_out | bits;
    if (offset == reg_gpio_clr) model_out = model_out & ~bits;
  end
endfunction

`endif

//--- sim/tb_io_subsystem.sv
//**************************************************************************
// Testbench for the I/O subsystem bus timing, GPIO and machine timer
//**************************************************************************

`timescale 1ns/1ps

module tb_io_subsystem
  import io_pkg::*;
();

  localparam int num_loops = 8;
  // Bus tasks per test section of about two cycles each
  localparam int planned_transactions = 15 + 8 * num_loops + 4 * num_loops + 2
                                        + 3 * num_loops + 14;
  localparam int timeout_cycles = planned_transactions * 4 + 200;

  logic                     clock = 1'b0;
  logic                     reset_n;
  logic [io_addr_width-1:0] rw_address;
  logic                     read_request;
  logic [31:0]              write_data;
  logic [3:0]               write_strobe;
  logic                     write_request;
  logic [31:0]              read_data;
  logic                     read_response;
  logic                     write_response;
  logic [gpio_width-1:0]    gpio_input;
  logic [gpio_width-1:0]    gpio_oe;
  logic [gpio_width-1:0]    gpio_output;
  logic                     timer_interrupt;

  int          errors = 0;
  int          cmp_errors = 0;
  logic        checking = 1'b0;
  logic        expect_check = 1'b0;
  logic [31:0] expect_value = '0;
  logic        read_pending = 1'b0;
  logic        write_pending = 1'b0;
  logic [31:0] last_read = '0;

  `include "tb_io_model.svh"

  always #20 clock = ~clock;

  io_subsystem dut (
    .clock           (clock),
    .reset_n         (reset_n),
    .rw_address      (rw_address),
    .read_request    (read_request),
    .write_data      (write_data),
    .write_strobe    (write_strobe),
    .write_request   (write_request),
    .read_data       (read_data),
    .read_response   (read_response),
    .write_response  (write_response),
    .gpio_input      (gpio_input),
    .gpio_oe         (gpio_oe),
    .gpio_output     (gpio_output),
    .timer_interrupt (timer_interrupt)
  );

  task automatic show_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] want);
    $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, want);
  endtask

  function automatic logic [io_addr_width-1:0] gpio_addr(input logic [offset_width-1:0] offset);
    return {region_gpio, offset};
  endfunction

  function automatic logic [io_addr_width-1:0] timer_addr(input logic [offset_width-1:0] offset);
    return {region_timer, offset};
  endfunction

  // Model follows on the edge where the DUT takes the write
  task automatic write_word(input logic [io_addr_width-1:0] address,
                            input logic [31:0] data, input logic [3:0] strobe);
    @(posedge clock);
    rw_address    <= address;
    write_data    <= data;
    write_strobe  <= strobe;
    write_request <= 1'b1;
    @(posedge clock);
    write_request <= 1'b0;
    apply_write(address, data, strobe);
  endtask

  // Returns the word captured in the response cycle
  task automatic read_word(input logic [io_addr_width-1:0] address, input logic check,
                           input logic [31:0] expected, output logic [31:0] data);
    @(posedge clock);
    expect_check = check;
    expect_value = expected;
    rw_address   <= address;
    read_request <= 1'b1;
    @(posedge clock);
    read_request <= 1'b0;
    @(negedge clock);
    #1;
    data = last_read;
  endtask

  task automatic check_gpio_read(input logic [offset_width-1:0] offset);
    logic [31:0] data;
    read_word(gpio_addr(offset), 1'b1, expected_gpio_read(offset, gpio_input), data);
  endtask

  // Responses one cycle after each request and zero data between reads
  always @(negedge clock) begin
    if (checking) begin
      if (read_response !== read_pending) begin
        show_mismatch("read_response", 32'(read_response), 32'(read_pending));
        cmp_errors++;
      end
      if (write_response !== write_pending) begin
        show_mismatch("write_response", 32'(write_response), 32'(write_pending));
        cmp_errors++;
      end
      if (read_response === 1'b1) begin
        last_read = read_data;
        if (expect_check && read_data !== expect_value) begin
          show_mismatch("read_data", read_data, expect_value);
          cmp_errors++;
        end
      end else if (read_data !== 32'd0) begin
        show_mismatch("idle read_data", read_data, 32'd0);
        cmp_errors++;
      end
      if (gpio_oe !== model_oe || gpio_output !== model_out) begin
        show_mismatch("gpio_oe,gpio_output", 32'({gpio_oe, gpio_output}),
                      32'({model_oe, model_out}));
        cmp_errors++;
      end
      read_pending  = read_request;
      write_pending = write_request;
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the test did not finish", timeout_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0]     data;
    logic [31:0]     time_a;
    logic [31:0]     time_b;
    logic [31:0]     rnd;
    logic [3:0]      strobe;
    logic [1:0]      mis;
    reset_n       = 1'b0;
    rw_address    = '0;
    read_request  = 1'b0;
    write_data    = '0;
    write_strobe  = '0;
    write_request = 1'b0;
    gpio_input    = '0;
    repeat (3) @(posedge clock);
    reset_n  <= 1'b1;
    checking = 1'b1;

    // Reset state and unmapped regions
    @(negedge clock);
    if (timer_interrupt !== 1'b0) begin
      show_mismatch("timer_interrupt after reset", 32'(timer_interrupt), 32'd0);
      errors++;
    end
    check_gpio_read(reg_gpio_oe);
    check_gpio_read(reg_gpio_out);
    read_word(timer_addr(reg_cmp_lo), 1'b1, 32'hFFFF_FFFF, data);
    for (int r = 2; r < 8; r++) begin
      read_word({3'(r), reg_gpio_in}, 1'b1, 32'd0, data);
      write_word({3'(r), reg_gpio_oe}, 32'hFFFF_FFFF, 4'hF);
    end

    // OE and OUT loads with dropped partial and misaligned writes
    for (int i = 0; i < num_loops; i++) begin
      write_word(gpio_addr(reg_gpio_oe), random_bits(32), 4'hF);
      write_word(gpio_addr(reg_gpio_out), random_bits(32), 4'hF);
      check_gpio_read(reg_gpio_oe);
      check_gpio_read(reg_gpio_out);
      rnd    = random_bits(6);
      strobe = (rnd[3:0] == 4'hF) ? 4'h7 : rnd[3:0];
      mis    = (rnd[5:4] == 2'b00) ? 2'b10 : rnd[5:4];
      write_word(gpio_addr(reg_gpio_out), random_bits(32), strobe);
      write_word(gpio_addr(reg_gpio_oe | {3'b000, mis}), random_bits(32), 4'hF);
      check_gpio_read(reg_gpio_oe);
      check_gpio_read(reg_gpio_out);
    end

    // SET and CLR
    for (int i = 0; i < num_loops; i++) begin
      write_word(gpio_addr(reg_gpio_set), random_bits(32), 4'hF);
      check_gpio_read(reg_gpio_out);
      write_word(gpio_addr(reg_gpio_clr), random_bits(32), 4'hF);
      check_gpio_read(reg_gpio_out);
    end
    check_gpio_read(reg_gpio_set);
    check_gpio_read(reg_gpio_clr);

    // Pin read-back with stable inputs
    for (int i = 0; i < num_loops; i++) begin
      write_word(gpio_addr(reg_gpio_oe), random_bits(32), 4'hF);
      rnd = random_bits(gpio_width);
      @(posedge clock);
      gpio_input <= rnd[gpio_width-1:0];
      @(negedge clock);
      check_gpio_read(reg_gpio_in);
    end

    // Six bus tasks of two cycles each mean 12 counts
    read_word(timer_addr(reg_time_lo), 1'b0, 32'd0, time_a);
    for (int i = 0; i < 5; i++) check_gpio_read(reg_gpio_out);
    read_word(timer_addr(reg_time_lo), 1'b0, 32'd0, time_b);
    if (time_b - time_a !== 32'd12) begin
      show_mismatch("time step", time_b - time_a, 32'd12);
      errors++;
    end

    // Compare at now plus 50
    read_word(timer_addr(reg_time_hi), 1'b1, 32'd0, data);
    read_word(timer_addr(reg_time_lo), 1'b0, 32'd0, time_a);
    write_word(timer_addr(reg_cmp_hi), 32'd0, 4'hF);
    write_word(timer_addr(reg_cmp_lo), time_a + 32'd50, 4'hF);
    repeat (39) @(negedge clock);
    if (timer_interrupt !== 1'b0) begin
      show_mismatch("early timer_interrupt", 32'(timer_interrupt), 32'd0);
      errors++;
    end
    repeat (22) @(negedge clock);
    if (timer_interrupt !== 1'b1) begin
      show_mismatch("timer_interrupt", 32'(timer_interrupt), 32'd1);
      errors++;
    end
    write_word(timer_addr(reg_cmp_lo), 32'hFFFF_FFFF, 4'hF);
    write_word(timer_addr(reg_cmp_hi), 32'hFFFF_FFFF, 4'hF);
    repeat (2) @(negedge clock);
    if (timer_interrupt !== 1'b0) begin
      show_mismatch("timer_interrupt after clear", 32'(timer_interrupt), 32'd0);
      errors++;
    end

    @(posedge clock);
    $display("Test finished with %0d sequence errors and %0d monitor errors",
             errors, cmp_errors);
    if (errors + cmp_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- src/io_subsystem.sv
//**************************************************************************
// I/O subsystem top: decoder, GPIO, machine timer and read mux
//**************************************************************************

`timescale 1ns/1ps

module io_subsystem
  import io_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset_n,

  // Register bus
  input  logic [io_addr_width-1:0] rw_address,
  input  logic                     read_request,
  input  logic [31:0]              write_data,
  input  logic [3:0]               write_strobe,
  input  logic                     write_request,
  output logic [31:0]              read_data,
  output logic                     read_response,
  output logic                     write_response,

  // Pins
  input  logic [gpio_width-1:0]    gpio_input,
  output logic [gpio_width-1:0]    gpio_oe,
  output logic [gpio_width-1:0]    gpio_output,

  output logic                     timer_interrupt
);

  logic                    gpio_read_request;
  logic                    gpio_write_request;
  logic                    timer_read_request;
  logic                    timer_write_request;
  logic [region_width-1:0] region;
  logic                    mapped;
  logic [31:0]             gpio_read_data;
  logic [31:0]             timer_read_data;

  io_request_decoder u_decoder (
    .rw_address          (rw_address),
    .read_request        (read_request),
    .write_request       (write_request),
    .gpio_read_request   (gpio_read_request),
    .gpio_write_request  (gpio_write_request),
    .timer_read_request  (timer_read_request),
    .timer_write_request (timer_write_request),
    .region              (region),
    .mapped              (mapped)
  );

  gpio #(
    .gpio_width (gpio_width)
  ) u_gpio (
    .clock         (clock),
    .reset_n       (reset_n),
    .offset        (rw_address[offset_width-1:0]),
    .write_data    (write_data),
    .write_strobe  (write_strobe),
    .read_request  (gpio_read_request),
    .write_request (gpio_write_request),
    .read_data     (gpio_read_data),
    .gpio_input    (gpio_input),
    .gpio_oe       (gpio_oe),
    .gpio_output   (gpio_output)
  );

  machine_timer u_timer (
    .clock           (clock),
    .reset_n         (reset_n),
    .offset          (rw_address[offset_width-1:0]),
    .write_data      (write_data),
    .write_strobe    (write_strobe),
    .read_request    (timer_read_request),
    .write_request   (timer_write_request),
    .read_data       (timer_read_data),
    .timer_interrupt (timer_interrupt)
  );

  // Sees the raw bus strobes so unmapped accesses still respond
  io_read_mux u_read_mux (
    .clock           (clock),
    .reset_n         (reset_n),
    .read_request    (read_request),
    .write_request   (write_request),
    .region          (region),
    .mapped          (mapped),
    .gpio_read_data  (gpio_read_data),
    .timer_read_data (timer_read_data),
    .read_data       (read_data),
    .read_response   (read_response),
    .write_response  (write_response)
  );

endmodule

//--- src/io_read_mux.sv
//**************************************************************************
// Read mux: merges peripheral read data and produces response pulses
//**************************************************************************

`timescale 1ns/1ps

module io_read_mux
  import io_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    read_request,
  input  logic                    write_request,
  input  logic [region_width-1:0] region,
  input  logic                    mapped,
  input  logic [31:0]             gpio_read_data,
  input  logic [31:0]             timer_read_data,
  output logic [31:0]             read_data,
  output logic                    read_response,
  output logic                    write_response
);

  logic [region_width-1:0] region_q;
  logic                    mapped_q;

  // Every request answers one cycle later, mapped or not
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
      region_q       <= '0;
      mapped_q       <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
      if (read_request || write_request) begin
        region_q <= region;
        mapped_q <= mapped;
      end
    end
  end

  // Zero unless this is a mapped read response
  always_comb begin
    read_data = 32'd0;
    if (read_response && mapped_q) begin
      case (region_q)
        region_gpio:  read_data = gpio_read_data;
        region_timer: read_data = timer_read_data;
        default:      read_data = 32'd0;
      endcase
    end
  end

endmodule

//--- timer/machine_timer.sv
//**************************************************************************
// Machine timer: 64-bit time counter with compare interrupt
//**************************************************************************

`timescale 1ns/1ps

module machine_timer
  import io_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset_n,

  // Register access
  input  logic [offset_width-1:0] offset,
  input  logic [31:0]             write_data,
  input  logic [3:0]              write_strobe,
  input  logic                    read_request,
  input  logic                    write_request,
  output logic [31:0]             read_data,

  output logic                    timer_interrupt
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        write_ok;
  logic        aligned;

  assign aligned  = (offset[1:0] == 2'b00);
  assign write_ok = write_request & aligned & (&write_strobe);

  // Time advances every cycle unless software loads a half
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mtime <= 64'd0;
    end else if (write_ok && offset == reg_time_lo) begin
      mtime <= {mtime[63:32], write_data};
    end else if (write_ok && offset == reg_time_hi) begin
      mtime <= {write_data, mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // Compare register
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mtimecmp <= cmp_reset_value;
    end else if (write_ok) begin
      case (offset)
        reg_cmp_lo: mtimecmp[31:0]  <= write_data;
        reg_cmp_hi: mtimecmp[63:32] <= write_data;
        default: ;
      endcase
    end
  end

  // Level interrupt, held while time has reached compare
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      timer_interrupt <= 1'b0;
    end else begin
      timer_interrupt <= (mtime >= mtimecmp);
    end
  end

  // Read data
  always_ff @(posedge clock) begin
    if (read_request && aligned) begin
      case (offset)
        reg_time_lo: read_data <= mtime[31:0];
        reg_time_hi: read_data <= mtime[63:32];
        reg_cmp_lo:  read_data <= mtimecmp[31:0];
        reg_cmp_hi:  read_data <= mtimecmp[63:32];
        default:     read_data <= 32'd0;
      endcase
    end else begin
      read_data <= 32'd0;
    end
  end

endmodule

//--- gpio/gpio.sv
//**************************************************************************
// GPIO block with direction, output, set and clear registers
//**************************************************************************

`timescale 1ns/1ps

module gpio
  import io_pkg::*;
#(
  parameter int gpio_width = io_pkg::gpio_width
) (
  input  logic                    clock,
  input  logic                    reset_n,

  // Register access
  input  logic [offset_width-1:0] offset,
  input  logic [31:0]             write_data,
  input  logic [3:0]              write_strobe,
  input  logic                    read_request,
  input  logic                    write_request,
  output logic [31:0]             read_data,

  // Pins
  input  logic [gpio_width-1:0]   gpio_input,
  output logic [gpio_width-1:0]   gpio_oe,
  output logic [gpio_width-1:0]   gpio_output
);

  logic [gpio_width-1:0] oe;
  logic [gpio_width-1:0] out;
  logic [gpio_width-1:0] wdata;
  logic                  aligned;
  logic                  full_word;
  logic [gpio_width-1:0] pin_value;
  logic [31:0]           pin_word;
  logic [31:0]           oe_word;
  logic [31:0]           out_word;

  assign gpio_oe     = oe;
  assign gpio_output = out;

  assign wdata     = write_data[gpio_width-1:0];
  assign aligned   = (offset[1:0] == 2'b00);
  assign full_word = &write_strobe;

  // Driven pins read back what we drive, the rest read the input
  assign pin_value = (oe & out) | (~oe & gpio_input);

  // Zero-extend pin-wide values to a bus word
  always_comb begin
    pin_word = '0;
    oe_word  = '0;
    out_word = '0;
    pin_word[gpio_width-1:0] = pin_value;
    oe_word[gpio_width-1:0]  = oe;
    out_word[gpio_width-1:0] = out;
  end

  // Register writes, full aligned words only
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      oe  <= '0;
      out <= '0;
    end else if (write_request && aligned && full_word) begin
      case (offset)
        reg_gpio_oe:  oe  <= wdata;
        reg_gpio_out: out <= wdata;
        reg_gpio_clr: out <= out & ~wdata;
        reg_gpio_set: out <= out | wdata;
        default: ;
      endcase
    end
  end

  // Read data, one cycle after the request
  always_ff @(posedge clock) begin
    if (read_request && aligned) begin
      case (offset)
        reg_gpio_in:  read_data <= pin_word;
        reg_gpio_oe:  read_data <= oe_word;
        reg_gpio_out: read_data <= out_word;
        default:      read_data <= 32'd0;
      endcase
    end else begin
      read_data <= 32'd0;
    end
  end

endmodule

//--- src/io_request_decoder.sv
//**************************************************************************
// Request decoder: steers bus request strobes to the owning peripheral
//**************************************************************************

`timescale 1ns/1ps

module io_request_decoder
  import io_pkg::*;
(
  // Bus request side
  input  logic [io_addr_width-1:0] rw_address,
  input  logic                     read_request,
  input  logic                     write_request,

  // Per-peripheral strobes
  output logic                     gpio_read_request,
  output logic                     gpio_write_request,
  output logic                     timer_read_request,
  output logic                     timer_write_request,

  // Destination tag for the read mux
  output logic [region_width-1:0]  region,
  output logic                     mapped
);

  logic hit_gpio;
  logic hit_timer;

  // Region field sits right above the register offset
  assign region = rw_address[io_addr_width-1:offset_width];

  assign hit_gpio  = (region == region_gpio);
  assign hit_timer = (region == region_timer);

  // Anything outside the two regions has no owner
  assign mapped = hit_gpio | hit_timer;

  // Only the owner sees the strobe
  assign gpio_read_request   = read_request  & hit_gpio;
  assign gpio_write_request  = write_request & hit_gpio;
  assign timer_read_request  = read_request  & hit_timer;
  assign timer_write_request = write_request & hit_timer;

endmodule

//--- common/io_pkg.sv
//**************************************************************************
// I/O subsystem package: address map, register offsets and widths
//**************************************************************************

package io_pkg;

  // Bus address layout: region in bits 7..5, register offset in bits 4..0
  localparam int io_addr_width = 8;
  localparam int region_width  = 3;
  localparam int offset_width  = 5;

  // Peripheral regions
  localparam logic [region_width-1:0] region_gpio  = 3'd0;
  localparam logic [region_width-1:0] region_timer = 3'd1;

  // Pin count of the GPIO block
  localparam int gpio_width = 8;

  // GPIO register offsets
  localparam logic [offset_width-1:0] reg_gpio_in  = 5'h00;
  localparam logic [offset_width-1:0] reg_gpio_oe  = 5'h04;
  localparam logic [offset_width-1:0] reg_gpio_out = 5'h08;
  localparam logic [offset_width-1:0] reg_gpio_clr = 5'h0C;
  localparam logic [offset_width-1:0] reg_gpio_set = 5'h10;

  // Machine timer register offsets
  localparam logic [offset_width-1:0] reg_time_lo = 5'h00;
  localparam logic [offset_width-1:0] reg_time_hi = 5'h04;
  localparam logic [offset_width-1:0] reg_cmp_lo  = 5'h08;
  localparam logic [offset_width-1:0] reg_cmp_hi  = 5'h0C;

  // Compare value out of reset, far enough away that no interrupt fires
  localparam logic [63:0] cmp_reset_value = 64'hFFFF_FFFF_FFFF_FFFF;

endpackage
